// ==== project.f ====
design/ufiPkg.sv
design/ufiCmdArbiter.sv
design/ufiTagFifo.sv
design/ufiMemBank.sv
design/ufiReadRouter.sv
design/ufiHub.sv
dv/ufiHub_chk.sv
dv/ufiHubTb.sv

// ==== Bender.yml ====
package:
  name: ufi_hub

sources:
  # Design, in compile order
  - design/ufiPkg.sv
  - design/ufiCmdArbiter.sv
  - design/ufiTagFifo.sv
  - design/ufiMemBank.sv
  - design/ufiReadRouter.sv
  - design/ufiHub.sv

  # Verification
  - target: simulation
    files:
      - dv/ufiHub_chk.sv
      - dv/ufiHubTb.sv

// ==== dv/ufiHubTb.sv ====
//--------------------------------------------------
// Testbench for the memory hub
// Table driven bursts, one phase at a time
// Masters of one phase start in the same cycle
// Only addresses written earlier are read back
// Stops at the first error
//--------------------------------------------------
`timescale 1ns/1ps

module ufiHubTb
	import ufiPkg::*;
();

	localparam int pReadLatency = 3;
	localparam int pTagDepth    = 4;
	localparam int retDelay     = pReadLatency + 2;	// Accepted beat to edd
	localparam int waitLimit    = 200;	// Cycles per wait loop

	// Table columns
	localparam int cPhase  = 0;
	localparam int cId     = 1;
	localparam int cWr     = 2;
	localparam int cAdrs   = 3;
	localparam int cBeats  = 4;
	localparam int cDelay  = 5;
	localparam int cOrder  = 6;
	localparam int nRows   = 10;
	localparam int nPhases = 6;

	// phase, master, write, start address, beats, start delay, grant order
	int stim [nRows][7] = '{
		'{0, idVtb, 1, 'h40, 16, 0, 0},	// Fill the shared area
		'{1, idMcs, 1, 'hc0,  8, 0, 0},
		'{2, idMcs, 0, 'h40,  4, 0, 0},	// All three at once
		'{2, idVtb, 0, 'h44,  6, 0, 1},
		'{2, idAtb, 0, 'h4a,  6, 0, 2},
		'{3, idVtb, 0, 'h40, 12, 0, 0},	// Mcs comes mid burst
		'{3, idMcs, 0, 'hc0,  8, 3, 1},
		'{4, idAtb, 0, 'h40, 16, 0, 0},	// Long read, FIFO fills
		'{5, idVtb, 1, 'h48,  4, 0, 0},	// Overwrite
		'{5, idAtb, 0, 'h46,  6, 0, 1}	// Then read across it
	};

	logic    iUfiClk;
	logic    rstN;
	logic    vdMcs, edMcs, weMcs;
	logic    vdVtb, edVtb, weVtb;
	logic    vdAtb, edAtb;
	ufiAdrsT adrsMcs, adrsVtb, adrsAtb;
	ufiDataT wdMcs, wdVtb;
	logic    rdyMcs, rdyVtb, rdyAtb;
	ufiDataT rd;
	logic    eddMcs, eddVtb, eddAtb;

	ufiDataT refMem [256];	// Reference RAM
	ufiDataT expData [$];	// Expected returns, issue order
	ufiIdT   expId [$];
	int      expDue [$];	// Cycle count when edd is due
	int      cycleCnt = 0;
	int      grantCnt = 0;	// Grants seen in this phase
	int      stallCnt = 0;	// Cycles the owner saw rdy low
	logic    burstOpen = 1'b0;	// Granted burst still has beats left

	ufiHub #(
		.pReadLatency(pReadLatency),
		.pTagDepth(pTagDepth)
	) UUT (
		.iUfiClk, .rstN,
		.vdMcs, .edMcs, .weMcs, .adrsMcs, .wdMcs, .rdyMcs,
		.vdVtb, .edVtb, .weVtb, .adrsVtb, .wdVtb, .rdyVtb,
		.vdAtb, .edAtb, .adrsAtb, .rdyAtb,
		.rd, .eddMcs, .eddVtb, .eddAtb
	);

	bind ufiHub ufiHubChk uChk (.*);	// Handshake assertions

	initial
	begin
		iUfiClk = 1'b0;
		forever
			#5 iUfiClk = ~iUfiClk;
	end

	//--------------------------------------------------
	// Error reporting and compare tasks
	//--------------------------------------------------
	task automatic abortRun();
		$display("Something failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkData(input string name, input ufiDataT got, input ufiDataT exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkId(input string name, input ufiIdT got, input ufiIdT exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCycle(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	//--------------------------------------------------
	// Master side helpers
	//--------------------------------------------------
	task automatic driveBeat(input ufiIdT id, input logic vd, input logic ed, input logic we,
		input ufiAdrsT adrs, input ufiDataT wd);
		case (id)
			idMcs:
			begin
				vdMcs   = vd;
				edMcs   = ed;
				weMcs   = we;
				adrsMcs = adrs;
				wdMcs   = wd;
			end
			idVtb:
			begin
				vdVtb   = vd;
				edVtb   = ed;
				weVtb   = we;
				adrsVtb = adrs;
				wdVtb   = wd;
			end
			default:
			begin
				vdAtb   = vd;
				edAtb   = ed;
				adrsAtb = adrs;	// No write path on Atb
			end
		endcase
	endtask

	function automatic logic rdyOf(input ufiIdT id);
		logic r;
		case (id)
			idMcs:   r = rdyMcs;
			idVtb:   r = rdyVtb;
			default: r = rdyAtb;
		endcase
		return r;
	endfunction

	// ID of the raised edd, idNone when all low
	function automatic ufiIdT eddId();
		ufiIdT id;
		id = idNone;
		if (eddMcs)
			id = idMcs;
		else if (eddVtb)
			id = idVtb;
		else if (eddAtb)
			id = idAtb;
		return id;
	endfunction

	function automatic int findRow(input int phase, input ufiIdT id);
		int hit;
		hit = -1;
		for (int r = 0; r < nRows; r++)
			if (stim[r][cPhase] == phase && stim[r][cId] == id)
				hit = r;
		return hit;
	endfunction

	// Master expected to win grant number order
	function automatic ufiIdT ownerAt(input int phase, input int order);
		ufiIdT id;
		id = idNone;
		for (int r = 0; r < nRows; r++)
			if (stim[r][cPhase] == phase && stim[r][cOrder] == order)
				id = ufiIdT'(stim[r][cId]);
		return id;
	endfunction

	// Called on the falling edge before the accepting edge
	task automatic noteAccept(input ufiIdT id, input logic we, input ufiAdrsT adrs,
		input ufiDataT wd);
		if (we)
			refMem[adrs] = wd;
		else
		begin
			expData.push_back(refMem[adrs]);
			expId.push_back(id);
			expDue.push_back(cycleCnt + 1 + retDelay);
		end
	endtask

	task automatic runMaster(input ufiIdT id, input int phase);
		int      row;
		int      beat;
		int      waitCnt;
		logic    granted;
		logic    isWr;
		ufiAdrsT adrs;
		ufiDataT wd;
		row = findRow(phase, id);
		if (row >= 0)
		begin
			isWr    = (stim[row][cWr] != 0);
			adrs    = ufiAdrsT'(stim[row][cAdrs]);
			wd      = isWr ? ufiDataT'($urandom) : '0;
			beat    = 0;
			waitCnt = 0;
			granted = 1'b0;
			repeat (stim[row][cDelay])
				@(negedge iUfiClk);
			driveBeat(id, 1'b1, 1'b1, isWr, adrs, wd);
			while (beat < stim[row][cBeats])
			begin
				if (rdyOf(id))	// Beat goes at the next rising edge
				begin
					if (!granted)
					begin
						checkFlag("burst open at grant", burstOpen, 1'b0);	// No preemption
						checkId("grant owner", id, ownerAt(phase, grantCnt));
						grantCnt++;
						granted   = 1'b1;
						burstOpen = 1'b1;
					end
					noteAccept(id, isWr, adrs, wd);
					beat++;
					waitCnt = 0;
					adrs    = adrs + 1'b1;
					wd      = isWr ? ufiDataT'($urandom) : '0;
				end
				else
				begin
					if (granted)
						stallCnt++;	// Tag FIFO full mid burst
					waitCnt++;
					if (waitCnt > waitLimit)
					begin
						$display("Master %0d got no rdy within %0d cycles", id, waitLimit);
						abortRun();
					end
				end
				@(negedge iUfiClk);
				if (beat < stim[row][cBeats])
					driveBeat(id, 1'b1, 1'b1, isWr, adrs, wd);	// Next or held beat
				else
				begin
					driveBeat(id, 1'b0, 1'b0, 1'b0, '0, '0);	// Burst done
					burstOpen = 1'b0;
				end
			end
		end
	endtask

	// Reads drained and arbiter released
	task automatic waitIdle();
		int waitCnt;
		waitCnt = 0;
		do
		begin
			@(negedge iUfiClk);
			waitCnt++;
			if (waitCnt > waitLimit)
			begin
				$display("Hub did not go idle within %0d cycles", waitLimit);
				abortRun();
			end
		end
		while (expData.size() != 0 || rdyMcs || rdyVtb || rdyAtb);
	endtask

	//--------------------------------------------------
	// Return monitor
	//--------------------------------------------------
	task automatic matchReturn();
		ufiDataT data;
		ufiIdT   id;
		int      due;
		if (expData.size() == 0)
		begin
			$display("Read data returned at %0t with no read outstanding", $time);
			abortRun();
		end
		else
		begin
			data = expData.pop_front();
			id   = expId.pop_front();
			due  = expDue.pop_front();
			checkCycle("edd cycle", cycleCnt, due);
			checkId("edd owner", eddId(), id);
			checkData("rd", rd, data);
		end
	endtask

	always @(negedge iUfiClk)
	begin
		if (rstN && (eddMcs || eddVtb || eddAtb))
			matchReturn();
	end

	// Queue settles on the falling edge, so count it here
	always @(posedge iUfiClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (expData.size() > pTagDepth)
		begin
			$display("More than %0d reads outstanding at %0t", pTagDepth, $time);
			abortRun();
		end
	end

	initial
	begin
		repeat (20000)
			@(posedge iUfiClk);
		$display("Run did not finish within 20000 cycles");
		abortRun();
	end

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial
	begin
		void'($urandom(32'hdc24_c50f));
		rstN = 1'b0;
		driveBeat(idMcs, 1'b0, 1'b0, 1'b0, '0, '0);
		driveBeat(idVtb, 1'b0, 1'b0, 1'b0, '0, '0);
		driveBeat(idAtb, 1'b0, 1'b0, 1'b0, '0, '0);
		repeat (10)
			@(negedge iUfiClk);
		rstN = 1'b1;
		repeat (6)	// No vd, so all quiet
		begin
			@(negedge iUfiClk);
			checkFlag("rdyMcs", rdyMcs, 1'b0);
			checkFlag("rdyVtb", rdyVtb, 1'b0);
			checkFlag("rdyAtb", rdyAtb, 1'b0);
			checkFlag("eddMcs", eddMcs, 1'b0);
			checkFlag("eddVtb", eddVtb, 1'b0);
			checkFlag("eddAtb", eddAtb, 1'b0);
		end
		for (int p = 0; p < nPhases; p++)
		begin
			grantCnt = 0;
			fork
				runMaster(idMcs, p);
				runMaster(idVtb, p);
				runMaster(idAtb, p);
			join
			waitIdle();
		end
		checkFlag("rdy back-pressure seen", stallCnt > 0, 1'b1);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== dv/ufiHub_chk.sv ====
//--------------------------------------------------
// Handshake and reset assertions, bound into ufiHub
// Reset is synchronous, outputs are checked
// one edge after rstN is seen low
//--------------------------------------------------
`timescale 1ns/1ps

module ufiHubChk (
	input logic iUfiClk,
	input logic rstN,
	input logic rdyMcs,
	input logic rdyVtb,
	input logic rdyAtb,
	input logic eddMcs,
	input logic eddVtb,
	input logic eddAtb,
	input logic tagFull	// Internal FIFO flag
);

	// One returned word per cycle
	aOneEdd: assert property (@(posedge iUfiClk) disable iff (!rstN)
		$onehot0({eddMcs, eddVtb, eddAtb}))
		else $error("More than one edd high");

	// Single owner
	aOneRdy: assert property (@(posedge iUfiClk) disable iff (!rstN)
		$onehot0({rdyMcs, rdyVtb, rdyAtb}))
		else $error("More than one rdy high");

	aRdyFull: assert property (@(posedge iUfiClk) disable iff (!rstN)
		tagFull |-> !(rdyMcs || rdyVtb || rdyAtb))
		else $error("rdy high while the tag FIFO is full");

	aResetLow: assert property (@(posedge iUfiClk)
		!rstN |=> !(rdyMcs || rdyVtb || rdyAtb || eddMcs || eddVtb || eddAtb))
		else $error("rdy or edd high after a reset edge");

endmodule

// ==== design/ufiHub.sv ====
//--------------------------------------------------
// Memory hub top, one clock domain
// Three masters, Mcs first, then Vtb, then Atb
// Read beat to rd and edd is pReadLatency+2 cycles
// At most pTagDepth reads outstanding
//--------------------------------------------------
`timescale 1ns/1ps

module ufiHub
	import ufiPkg::*;
#(
	parameter int pReadLatency = 3,
	parameter int pTagDepth    = 4
)(
	input  logic    iUfiClk,
	input  logic    rstN,
	// Mcs master
	input  logic    vdMcs,
	input  logic    edMcs,
	input  logic    weMcs,
	input  ufiAdrsT adrsMcs,
	input  ufiDataT wdMcs,
	output logic    rdyMcs,
	// Vtb master
	input  logic    vdVtb,
	input  logic    edVtb,
	input  logic    weVtb,
	input  ufiAdrsT adrsVtb,
	input  ufiDataT wdVtb,
	output logic    rdyVtb,
	// Atb master
	input  logic    vdAtb,
	input  logic    edAtb,
	input  ufiAdrsT adrsAtb,
	output logic    rdyAtb,
	// Read return
	output ufiDataT rd,
	output logic    eddMcs,
	output logic    eddVtb,
	output logic    eddAtb
);

	//--------------------------------------------------
	// Internal nets
	//--------------------------------------------------
	logic    ramWe;
	logic    ramRe;
	ufiAdrsT ramAdrs;
	ufiDataT ramWd;
	logic    tagPush;
	ufiIdT   tagId;
	ufiIdT   tagHead;
	logic    tagFull;
	ufiDataT memRd;
	logic    memRdValid;	// Also pops the tag FIFO

	// Command side
	ufiCmdArbiter uArb (
		.iUfiClk, .rstN,
		.vdMcs, .edMcs, .weMcs, .adrsMcs, .wdMcs, .rdyMcs,
		.vdVtb, .edVtb, .weVtb, .adrsVtb, .wdVtb, .rdyVtb,
		.vdAtb, .edAtb, .adrsAtb, .rdyAtb,
		.tagFull,
		.ramWe, .ramRe, .ramAdrs, .ramWd,
		.tagPush, .tagId
	);

	// Tags wait here while the RAM works
	ufiTagFifo #(.pTagDepth(pTagDepth)) uTag (
		.iUfiClk, .rstN,
		.tagPush, .tagId,
		.tagPop(memRdValid),
		.tagHead, .tagFull
	);

	ufiMemBank #(.pReadLatency(pReadLatency)) uMem (
		.iUfiClk, .rstN,
		.ramWe, .ramRe, .ramAdrs, .ramWd,
		.memRd, .memRdValid
	);

	// Return side
	ufiReadRouter uRoute (
		.iUfiClk, .rstN,
		.memRd, .memRdValid, .tagHead,
		.rd, .eddMcs, .eddVtb, .eddAtb
	);

endmodule

// ==== design/ufiReadRouter.sv ====
//--------------------------------------------------
// Pairs each returned word with the head tag
// One edd per word, registered
// rd is shared by all masters
//--------------------------------------------------
`timescale 1ns/1ps

module ufiReadRouter
	import ufiPkg::*;
(
	input  logic    iUfiClk,
	input  logic    rstN,
	input  ufiDataT memRd,
	input  logic    memRdValid,
	input  ufiIdT   tagHead,	// ID of the oldest read
	output ufiDataT rd,
	output logic    eddMcs,
	output logic    eddVtb,
	output logic    eddAtb
);

	// ID decode of the head tag
	logic hitMcs;
	logic hitVtb;
	logic hitAtb;

	assign hitMcs = (tagHead == idMcs);
	assign hitVtb = (tagHead == idVtb);
	assign hitAtb = (tagHead == idAtb);

	// Data needs no reset, edd qualifies it
	always_ff @(posedge iUfiClk)
	begin
		rd <= memRd;
	end

	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			eddMcs <= 1'b0;
			eddVtb <= 1'b0;
			eddAtb <= 1'b0;
		end
		else
		begin
			eddMcs <= memRdValid && hitMcs;
			eddVtb <= memRdValid && hitVtb;
			eddAtb <= memRdValid && hitAtb;	// idNone never matches
		end
	end

endmodule

// ==== design/ufiMemBank.sv ====
//--------------------------------------------------
// Synchronous 256 word RAM
// Write lands on the edge that samples ramWe
// Read data valid pReadLatency cycles after
// the RAM output register
// Contents after reset are undefined
//--------------------------------------------------
`timescale 1ns/1ps

module ufiMemBank
	import ufiPkg::*;
#(
	parameter int pReadLatency = 3
)(
	input  logic    iUfiClk,
	input  logic    rstN,
	input  logic    ramWe,
	input  logic    ramRe,
	input  ufiAdrsT ramAdrs,
	input  ufiDataT ramWd,
	output ufiDataT memRd,
	output logic    memRdValid
);

	localparam int pWords = 2 ** ufiAdrsW;

	ufiDataT memArray [pWords];

	// Stage 0 is the RAM output register
	// Stages 1 up to pReadLatency are the read pipe
	ufiDataT pipeRd [pReadLatency + 1];
	logic    pipeVd [pReadLatency + 1];

	//--------------------------------------------------
	// Array and data pipe
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (ramWe)
			memArray[ramAdrs] <= ramWd;
		if (ramRe)
			pipeRd[0] <= memArray[ramAdrs];	// Read port only on a read
		for (int i = 1; i <= pReadLatency; i++)
			pipeRd[i] <= pipeRd[i-1];
	end

	//--------------------------------------------------
	// Valid pipe
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i <= pReadLatency; i++)
				pipeVd[i] <= 1'b0;
		end
		else
		begin
			pipeVd[0] <= ramRe;
			for (int i = 1; i <= pReadLatency; i++)
				pipeVd[i] <= pipeVd[i-1];
		end
	end

	// Several reads may be in flight, one per stage
	assign memRd      = pipeRd[pReadLatency];
	assign memRdValid = pipeVd[pReadLatency];

endmodule

// ==== design/ufiTagFifo.sv ====
//--------------------------------------------------
// In order FIFO of read IDs
// Depth sets the max number of reads in flight
// tagFull counts a push of this cycle as taken
// Pop on an empty FIFO is not allowed
//--------------------------------------------------
`timescale 1ns/1ps

module ufiTagFifo
	import ufiPkg::*;
#(
	parameter int pTagDepth = 4
)(
	input  logic  iUfiClk,
	input  logic  rstN,
	input  logic  tagPush,
	input  ufiIdT tagId,
	input  logic  tagPop,
	output ufiIdT tagHead,
	output logic  tagFull
);

	localparam int pPtrW = (pTagDepth > 1) ? $clog2(pTagDepth) : 1;
	localparam int pCntW = $clog2(pTagDepth + 1);

	ufiIdT            idMem [pTagDepth];	// Circular buffer
	logic [pPtrW-1:0] wrPtr;
	logic [pPtrW-1:0] rdPtr;
	logic [pCntW-1:0] count;	// Tags held
	logic [pCntW:0]   fill;	// Held plus the pending push

	// Wrap works for any depth, not just powers of two
	function automatic logic [pPtrW-1:0] ptrInc(input logic [pPtrW-1:0] ptr);
		logic [pPtrW-1:0] nxt;
		if (ptr == pPtrW'(pTagDepth - 1))
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	//--------------------------------------------------
	// Storage
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (tagPush)
			idMem[wrPtr] <= tagId;
	end

	assign tagHead = idMem[rdPtr];	// Valid while count is nonzero

	//--------------------------------------------------
	// Pointers and count
	//--------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (tagPush)
				wrPtr <= ptrInc(wrPtr);
			if (tagPop)
				rdPtr <= ptrInc(rdPtr);
			case ({tagPush, tagPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or none
			endcase
		end
	end

	// Push is one cycle behind the accepted beat, so count it here
	assign fill    = {1'b0, count} + {{pCntW{1'b0}}, tagPush};
	assign tagFull = (fill >= pTagDepth);

endmodule

// ==== design/ufiCmdArbiter.sv ====
//--------------------------------------------------
// Burst locked fixed priority arbiter
// Owner keeps the RAM until its vd falls
// No preemption of a running burst
// One idle cycle between two bursts
// Accepted beats reach the RAM one cycle later
//--------------------------------------------------
`timescale 1ns/1ps

module ufiCmdArbiter
	import ufiPkg::*;
(
	input  logic    iUfiClk,
	input  logic    rstN,
	// Mcs master
	input  logic    vdMcs,
	input  logic    edMcs,
	input  logic    weMcs,
	input  ufiAdrsT adrsMcs,
	input  ufiDataT wdMcs,
	output logic    rdyMcs,
	// Vtb master
	input  logic    vdVtb,
	input  logic    edVtb,
	input  logic    weVtb,
	input  ufiAdrsT adrsVtb,
	input  ufiDataT wdVtb,
	output logic    rdyVtb,
	// Atb master, reads only
	input  logic    vdAtb,
	input  logic    edAtb,
	input  ufiAdrsT adrsAtb,
	output logic    rdyAtb,
	// Tag FIFO back-pressure
	input  logic    tagFull,
	// RAM command
	output logic    ramWe,
	output logic    ramRe,
	output ufiAdrsT ramAdrs,
	output ufiDataT ramWd,
	// Read tag
	output logic    tagPush,
	output ufiIdT   tagId
);

	typedef enum logic [1:0] {arbIdle, arbMcs, arbVtb, arbAtb} arbStateT;

	arbStateT state;
	arbStateT stateNext;

	// Owner's beat, muxed by state
	logic    ownerVd;
	logic    ownerEd;
	logic    ownerWe;
	ufiAdrsT ownerAdrs;
	ufiDataT ownerWd;
	ufiIdT   ownerId;
	logic    accept;	// Beat taken at this edge

	//--------------------------------------------------
	// Owner mux
	//--------------------------------------------------
	always_comb
	begin
		ownerVd   = 1'b0;
		ownerEd   = 1'b0;
		ownerWe   = 1'b0;
		ownerAdrs = '0;
		ownerWd   = '0;
		ownerId   = idNone;
		case (state)
			arbMcs:
			begin
				ownerVd   = vdMcs;
				ownerEd   = edMcs;
				ownerWe   = weMcs;
				ownerAdrs = adrsMcs;
				ownerWd   = wdMcs;
				ownerId   = idMcs;
			end
			arbVtb:
			begin
				ownerVd   = vdVtb;
				ownerEd   = edVtb;
				ownerWe   = weVtb;
				ownerAdrs = adrsVtb;
				ownerWd   = wdVtb;
				ownerId   = idVtb;
			end
			arbAtb:
			begin
				ownerVd   = vdAtb;
				ownerEd   = edAtb;
				ownerAdrs = adrsAtb;	// Write enable stays low
				ownerId   = idAtb;
			end
			default:
			begin
				ownerVd = 1'b0;	// Nobody owns the RAM
			end
		endcase
	end

	// Ready only for the owner, and only with tag room
	assign rdyMcs = (state == arbMcs) && !tagFull;
	assign rdyVtb = (state == arbVtb) && !tagFull;
	assign rdyAtb = (state == arbAtb) && !tagFull;
	assign accept = ownerEd && !tagFull;	// ownerEd is low when idle

	//--------------------------------------------------
	// Ownership FSM
	//--------------------------------------------------
	always_comb
	begin
		stateNext = state;
		if (state == arbIdle)
		begin
			if (vdMcs)
				stateNext = arbMcs;
			else if (vdVtb)
				stateNext = arbVtb;
			else if (vdAtb)
				stateNext = arbAtb;
		end
		else if (!ownerVd)
			stateNext = arbIdle;	// Burst over, release
	end

	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			state <= arbIdle;
			ramWe <= 1'b0;
			ramRe <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			ramWe <= accept && ownerWe;
			ramRe <= accept && !ownerWe;
		end
	end

	// Payload, no reset
	always_ff @(posedge iUfiClk)
	begin
		ramAdrs <= ownerAdrs;
		ramWd   <= ownerWd;
		tagId   <= ownerId;
	end

	assign tagPush = ramRe;	// Tag goes in with the read command

endmodule

// ==== design/ufiPkg.sv ====
//--------------------------------------------------
// Shared widths, types and master IDs of the hub
// RAM is word addressed, 256 words of 8 bits
// ID 0 is reserved for "no owner"
//--------------------------------------------------
package ufiPkg;

	//--------------------------------------------------
	// Bus widths
	//--------------------------------------------------
	localparam int ufiDataW = 8;	// Same as the RAM word
	localparam int ufiAdrsW = 8;	// 256 words

	typedef logic [ufiDataW-1:0] ufiDataT;	// One data word
	typedef logic [ufiAdrsW-1:0] ufiAdrsT;	// One word address

	// Master ID carried with every read beat
	typedef logic [1:0] ufiIdT;

	//--------------------------------------------------
	// Master IDs
	//--------------------------------------------------
	// Idle value, never pushed into the tag FIFO
	localparam ufiIdT idNone = 2'd0;

	// Control processor, highest priority
	localparam ufiIdT idMcs = 2'd1;

	// Video transfer block, reads and writes
	localparam ufiIdT idVtb = 2'd2;

	// Audio transfer block, reads only
	localparam ufiIdT idAtb = 2'd3;

	// Priority order is Mcs, Vtb, Atb
	// Fixed in the arbiter, not by ID value

endpackage
